// ==== all.f ====
+incdir+logic
logic/gat_pkg.sv
logic/input_bram.sv
logic/spmm_engine.sv
logic/feat_bram_arbiter.sv
logic/gat_top.sv
test/gat_checker.sv
test/gat_tb.sv

// ==== test/gat_tb.sv ====
`timescale 1ns/1ns

`include "gat_consts.svh"

module gat_tb
  import gat_pkg::*;
();

  localparam int CLK_NS     = 4;
  localparam int NODES      = `GAT_TOTAL_NODES;
  localparam int FIN        = `GAT_NUM_FEATURE_IN;
  localparam int FOUT       = `GAT_NUM_FEATURE_OUT;
  localparam int NFW        = `GAT_NEW_FEATURE_WIDTH;
  localparam int WHW        = `GAT_WH_DATA_WIDTH;
  localparam int EMPTY_NODE = 2;
  localparam int NEG_NODE   = 5;
  localparam int READ_LIMIT = 8;
  // Worst case, every H word streamed for every output feature
  localparam int STEPS      = `GAT_H_DATA_DEPTH * FOUT + `GAT_FEAT_DEPTH;
  localparam int COMPUTE_LIMIT = 8 * STEPS;
  // Longer than a full compute pass
  localparam int IDLE_CYCLES   = 2 * STEPS;
  localparam int LOAD_CYCLES   = `GAT_H_DATA_DEPTH + NODES + `GAT_WEIGHT_DEPTH + 32;
  localparam int READ_CYCLES   = 2 * READ_LIMIT * `GAT_FEAT_DEPTH;
  localparam int WATCHDOG_CYCLES = COMPUTE_LIMIT + IDLE_CYCLES + LOAD_CYCLES +
                                   READ_CYCLES + 64;

  logic           clk;
  logic           rst_n;
  h_data_wr_t     h_wr;
  node_info_wr_t  node_wr;
  wgt_wr_t        wgt_wr;
  logic           h_done;
  logic           node_done;
  logic           wgt_done;
  feat_rd_req_t   feat_rd;
  logic           gat_ready;
  logic           rvalid;
  logic [NFW-1:0] dout;

  // Software copy of the loaded data and the expected sums
  integer                seed;
  int                    errors;
  int                    mark;
  int                    tests_run;
  int                    tests_failed;
  int                    nnz_total;
  int                    row_len  [NODES];
  logic signed [7:0]     h_val    [`GAT_H_DATA_DEPTH];
  logic        [3:0]     h_col    [`GAT_H_DATA_DEPTH];
  logic signed [7:0]     wgt      [`GAT_WEIGHT_DEPTH];
  logic [NFW-1:0]        expected [`GAT_FEAT_DEPTH];

  gat_top dut_i (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .h_data_bram                (h_wr),
    .h_node_info_bram           (node_wr),
    .wgt_bram                   (wgt_wr),
    .h_data_bram_load_done      (h_done),
    .h_node_info_bram_load_done (node_done),
    .wgt_bram_load_done         (wgt_done),
    .feat_rd                    (feat_rd),
    .gat_ready                  (gat_ready),
    .feat_bram_rvalid           (rvalid),
    .feat_bram_dout             (dout)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_word(input string name, input int idx,
                              input logic [NFW-1:0] exp, input logic [NFW-1:0] act);
    assert (act === exp) else begin
      $display("FAIL %0t ns %s[%0d] expected %h actual %h", $time, name, idx, exp, act);
      errors++;
    end
  endtask

  task automatic expect_level(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("FAIL %0t ns %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input int num, input string name);
    tests_run++;
    if (errors == mark) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", num, name, errors - mark);
    end
    mark = errors;
  endtask

  // Sum over row n of value times W(col, f), kept to 20 bits signed
  function automatic logic [NFW-1:0] model_sum(input int n, input int f);
    int                    base;
    int                    s;
    int                    j;
    logic signed [WHW-1:0] s20;
    base = 0;
    for (j = 0; j < n; j++) begin
      base += row_len[j];
    end
    s = 0;
    for (j = 0; j < row_len[n]; j++) begin
      s += int'(h_val[base + j]) * int'(wgt[h_col[base + j] * FOUT + f]);
    end
    s20 = s[WHW-1:0];
    return {{(NFW-WHW){s20[WHW-1]}}, s20};
  endfunction

  task automatic build_data();
    int n;
    int j;
    int f;
    int base;
    int v;
    base = 0;
    for (n = 0; n < NODES; n++) begin
      row_len[n] = (n == EMPTY_NODE) ? 0 : {$random(seed)} % 8;
      if (n == NEG_NODE && row_len[n] == 0) begin
        row_len[n] = 4;
      end
      for (j = 0; j < row_len[n]; j++) begin
        if (n == NEG_NODE) begin
          v = -(1 + ({$random(seed)} % 127));
        end else begin
          v = $random(seed);
        end
        h_val[base + j] = v[7:0];
        v = {$random(seed)} % FIN;
        h_col[base + j] = v[3:0];
      end
      base += row_len[n];
    end
    nnz_total = base;
    for (j = 0; j < `GAT_WEIGHT_DEPTH; j++) begin
      v = $random(seed);
      wgt[j] = v[7:0];
    end
    for (n = 0; n < NODES; n++) begin
      for (f = 0; f < FOUT; f++) begin
        expected[n * FOUT + f] = model_sum(n, f);
      end
    end
  endtask

  task automatic load_memories();
    int i;
    for (i = 0; i < nnz_total; i++) begin
      h_wr = '{ena: 1'b1, wea: 1'b1, addra: i[`GAT_H_DATA_ADDR_W-1:0],
               din: '{value: h_val[i], col_idx: h_col[i]}};
      next_cycle();
    end
    h_wr = '0;
    for (i = 0; i < NODES; i++) begin
      node_wr = '{ena: 1'b1, wea: 1'b1, addra: i[`GAT_NODE_ADDR_W-1:0],
                  din: row_len[i][`GAT_ROW_LEN_WIDTH-1:0]};
      next_cycle();
    end
    node_wr = '0;
    for (i = 0; i < `GAT_WEIGHT_DEPTH; i++) begin
      wgt_wr = '{ena: 1'b1, wea: 1'b1, addra: i[`GAT_WEIGHT_ADDR_W-1:0], din: wgt[i]};
      next_cycle();
    end
    wgt_wr = '0;
  endtask

  // Holds rd_en and the address until rvalid, lat counts the edges waited
  task automatic read_word(input int addr, output logic [NFW-1:0] data, output int lat);
    logic got;
    got  = 1'b0;
    lat  = 0;
    data = 'x;
    feat_rd.addr  = addr[`GAT_FEAT_ADDR_W-1:0];
    feat_rd.rd_en = 1'b1;
    while (!got && lat < READ_LIMIT) begin
      next_cycle();
      lat++;
      if (rvalid) begin
        got  = 1'b1;
        data = dout;
      end
    end
    feat_rd.rd_en = 1'b0;
    assert (got) else begin
      $display("Read of address %0d was dropped, no rvalid in %0d cycles", addr, READ_LIMIT);
      errors++;
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    int             a;
    int             f;
    int             lat;
    int             cycles;
    int             stalls;
    int             checker_fails;
    logic [NFW-1:0] d;
    seed         = 32'h671d_3ebb;
    errors       = 0;
    mark         = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b1;
    h_wr         = '0;
    node_wr      = '0;
    wgt_wr       = '0;
    h_done       = 1'b0;
    node_done    = 1'b0;
    wgt_done     = 1'b0;
    feat_rd      = '0;
    build_data();
    #1 rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    // Quiet after reset, and no start on two of three load-done levels
    expect_level("gat_ready", 1'b0, gat_ready);
    expect_level("feat_bram_rvalid", 1'b0, rvalid);
    load_memories();
    h_done = 1'b1;
    next_cycle();
    node_done = 1'b1;
    // An engine started early would reach gat_ready in this window
    repeat (IDLE_CYCLES) begin
      next_cycle();
      expect_level("gat_ready", 1'b0, gat_ready);
    end
    finish_test(1, "reset and partial load");

    // Host keeps reading while the engine writes results
    wgt_done = 1'b1;
    cycles   = 0;
    stalls   = 0;
    a        = 0;
    while (!gat_ready && cycles < COMPUTE_LIMIT) begin
      read_word(a, d, lat);
      cycles += lat;
      if (lat > 1) begin
        stalls++;
      end
      a = (a + 1) % `GAT_FEAT_DEPTH;
    end
    assert (gat_ready) else begin
      $display("gat_ready did not rise within %0d cycles of the last load-done", cycles);
      errors++;
    end
    assert (stalls > 0) else begin
      $display("No read was held behind an engine write during compute");
      errors++;
    end
    repeat (4) begin
      next_cycle();
      expect_level("gat_ready", 1'b1, gat_ready);
    end
    finish_test(2, $sformatf("compute and ready, %0d reads held behind writes", stalls));

    for (a = 0; a < `GAT_FEAT_DEPTH; a++) begin
      read_word(a, d, lat);
      compare_word("feat_bram_dout", a, expected[a], d);
      expect_level("gat_ready", 1'b1, gat_ready);
    end
    finish_test(3, "full readback");

    // Empty row gives zero, negative row needs the upper 12 bits filled
    for (f = 0; f < FOUT; f++) begin
      read_word(EMPTY_NODE * FOUT + f, d, lat);
      compare_word("feat_bram_dout", EMPTY_NODE * FOUT + f, '0, d);
      read_word(NEG_NODE * FOUT + f, d, lat);
      compare_word("feat_bram_dout", NEG_NODE * FOUT + f, expected[NEG_NODE * FOUT + f], d);
    end
    finish_test(4, "empty and negative rows");

    // Back to back, one edge each once idle
    for (f = 0; f < FOUT; f++) begin
      a = (NODES - 1) * FOUT + f;
      read_word(a, d, lat);
      assert (lat == 1) else begin
        $display("FAIL %0t ns read latency[%0d] expected 1 actual %0d", $time, a, lat);
        errors++;
      end
      compare_word("feat_bram_dout", a, expected[a], d);
    end
    finish_test(5, "read handshake");

    checker_fails = dut_i.gat_checker_i.fail_count;
    errors += checker_fails;
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d, checker failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors, checker_fails);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== test/gat_checker.sv ====
`timescale 1ns/1ns

module gat_checker (
  input logic clk,
  input logic rst_n,
  input logic gat_ready,
  input logic rvalid,
  input logic rd_en,
  input logic wr_en
);

  // Count of assertion failures
  int fail_count = 0;

  // ==========================================================================
  // Handshake and status properties
  // ==========================================================================

  // Both outputs held clear during reset
  reset_quiet_a: assert property (@(posedge clk) !rst_n |-> !gat_ready && !rvalid)
    else begin
      $error("gat_ready or feat_bram_rvalid high during reset");
      fail_count++;
    end

  // Done is sticky
  ready_sticky_a: assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready |=> gat_ready)
    else begin
      $error("gat_ready fell before reset");
      fail_count++;
    end

  // Engine idle, so every request is granted at once
  read_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready && rd_en |=> rvalid)
    else begin
      $error("rvalid missing one cycle after rd_en with gat_ready high");
      fail_count++;
    end

  // Engine write wins the port
  write_priority_a: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |=> !rvalid)
    else begin
      $error("read granted in a cycle with an engine write");
      fail_count++;
    end

endmodule

bind gat_top gat_checker gat_checker_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .gat_ready (gat_ready),
  .rvalid    (feat_bram_rvalid),
  .rd_en     (feat_rd.rd_en),
  .wr_en     (feat_wr.en)
);

// ==== logic/gat_top.sv ====
`timescale 1ns/1ns

`include "gat_consts.svh"

module gat_top
  import gat_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,

  // Host loading
  input  h_data_wr_t                          h_data_bram,
  input  node_info_wr_t                       h_node_info_bram,
  input  wgt_wr_t                             wgt_bram,
  input  logic                                h_data_bram_load_done,
  input  logic                                h_node_info_bram_load_done,
  input  logic                                wgt_bram_load_done,

  // Host readback
  input  feat_rd_req_t                        feat_rd,
  output logic                                gat_ready,
  output logic                                feat_bram_rvalid,
  output logic [`GAT_NEW_FEATURE_WIDTH-1:0]   feat_bram_dout
);

  // ==========================================================================
  // Engine side of the input memories
  // ==========================================================================

  logic [`GAT_H_DATA_ADDR_W-1:0] h_data_addrb;
  logic                          h_data_rd_en;
  h_data_t                       h_data_dout;

  logic [`GAT_NODE_ADDR_W-1:0]   node_info_addrb;
  logic                          node_info_rd_en;
  logic [`GAT_ROW_LEN_WIDTH-1:0] node_info_dout;

  logic [`GAT_WEIGHT_ADDR_W-1:0] wgt_addrb;
  logic                          wgt_rd_en;
  logic [`GAT_DATA_WIDTH-1:0]    wgt_dout;

  // Finished sums towards the result memory
  feat_wr_t                      feat_wr;

  // ==========================================================================
  // Input memories
  // ==========================================================================

  // H nonzeros, row after row
  input_bram #(
    .WIDTH ($bits(h_data_t)),
    .DEPTH (`GAT_H_DATA_DEPTH)
  ) h_data_bram_i (
    .clk   (clk),
    .wr    (h_data_bram),
    .addrb (h_data_addrb),
    .rd_en (h_data_rd_en),
    .doutb (h_data_dout)
  );

  // Nonzero count per node
  input_bram #(
    .WIDTH (`GAT_ROW_LEN_WIDTH),
    .DEPTH (`GAT_TOTAL_NODES)
  ) node_info_bram_i (
    .clk   (clk),
    .wr    (h_node_info_bram),
    .addrb (node_info_addrb),
    .rd_en (node_info_rd_en),
    .doutb (node_info_dout)
  );

  // W at c * 16 + f
  input_bram #(
    .WIDTH (`GAT_DATA_WIDTH),
    .DEPTH (`GAT_WEIGHT_DEPTH)
  ) wgt_bram_i (
    .clk   (clk),
    .wr    (wgt_bram),
    .addrb (wgt_addrb),
    .rd_en (wgt_rd_en),
    .doutb (wgt_dout)
  );

  // ==========================================================================
  // Compute and result storage
  // ==========================================================================

  spmm_engine spmm_engine_i (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .h_data_dout                (h_data_dout),
    .node_info_dout             (node_info_dout),
    .wgt_dout                   (wgt_dout),
    .h_data_addrb               (h_data_addrb),
    .node_info_addrb            (node_info_addrb),
    .wgt_addrb                  (wgt_addrb),
    .h_data_rd_en               (h_data_rd_en),
    .node_info_rd_en            (node_info_rd_en),
    .wgt_rd_en                  (wgt_rd_en),
    .feat_wr                    (feat_wr),
    .gat_ready                  (gat_ready)
  );

  feat_bram_arbiter feat_bram_arbiter_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .feat_wr          (feat_wr),
    .feat_rd          (feat_rd),
    .feat_bram_rvalid (feat_bram_rvalid),
    .feat_bram_dout   (feat_bram_dout)
  );

endmodule

// ==== logic/feat_bram_arbiter.sv ====
`timescale 1ns/1ns

`include "gat_consts.svh"

module feat_bram_arbiter
  import gat_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  feat_wr_t                            feat_wr,
  input  feat_rd_req_t                        feat_rd,
  output logic                                feat_bram_rvalid,
  output logic [`GAT_NEW_FEATURE_WIDTH-1:0]   feat_bram_dout
);

  localparam int WHW   = `GAT_WH_DATA_WIDTH;
  localparam int NFW   = `GAT_NEW_FEATURE_WIDTH;
  localparam int DEPTH = `GAT_FEAT_DEPTH;

  // ==========================================================================
  // Single-port result memory
  // ==========================================================================

  logic signed [WHW-1:0] mem [DEPTH];
  logic signed [WHW-1:0] rd_q;
  logic                  rd_grant;

  // Engine write wins, host read waits a cycle
  assign rd_grant = feat_rd.rd_en && !feat_wr.en;

  always_ff @(posedge clk) begin
    if (feat_wr.en) begin
      mem[feat_wr.addr] <= feat_wr.data;
    end else if (rd_grant) begin
      rd_q <= mem[feat_rd.addr];
    end
  end

  // ==========================================================================
  // Read response
  // ==========================================================================

  // One pulse per granted read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_bram_rvalid <= 1'b0;
    end else begin
      feat_bram_rvalid <= rd_grant;
    end
  end

  // Signed sum widened for the host
  assign feat_bram_dout = {{(NFW-WHW){rd_q[WHW-1]}}, rd_q};

endmodule

// ==== logic/spmm_engine.sv ====
`timescale 1ns/1ns

`include "gat_consts.svh"

module spmm_engine
  import gat_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            h_data_bram_load_done,
  input  logic                            h_node_info_bram_load_done,
  input  logic                            wgt_bram_load_done,
  input  h_data_t                         h_data_dout,
  input  logic [`GAT_ROW_LEN_WIDTH-1:0]   node_info_dout,
  input  logic [`GAT_DATA_WIDTH-1:0]      wgt_dout,
  output logic [`GAT_H_DATA_ADDR_W-1:0]   h_data_addrb,
  output logic [`GAT_NODE_ADDR_W-1:0]     node_info_addrb,
  output logic [`GAT_WEIGHT_ADDR_W-1:0]   wgt_addrb,
  output logic                            h_data_rd_en,
  output logic                            node_info_rd_en,
  output logic                            wgt_rd_en,
  output feat_wr_t                        feat_wr,
  output logic                            gat_ready
);

  localparam int DW        = `GAT_DATA_WIDTH;
  localparam int WHW       = `GAT_WH_DATA_WIDTH;
  localparam int HAW       = `GAT_H_DATA_ADDR_W;
  localparam int RLW       = `GAT_ROW_LEN_WIDTH;
  localparam int NAW       = `GAT_NODE_ADDR_W;
  localparam int FW        = `GAT_FEAT_ADDR_W - `GAT_NODE_ADDR_W;
  localparam int LAST_NODE = `GAT_TOTAL_NODES - 1;
  localparam int LAST_FEAT = `GAT_NUM_FEATURE_OUT - 1;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_STREAM,
    S_DRAIN,
    S_DONE
  } state_t;

  // ==========================================================================
  // Walk state
  // ==========================================================================

  state_t               state;
  logic                 all_loaded;
  logic                 len_req;
  logic [NAW-1:0]       node;
  logic [FW-1:0]        feat;
  logic [HAW-1:0]       row_base;
  logic [RLW-1:0]       row_len;
  logic [RLW-1:0]       k;
  logic                 issue;
  logic                 issue_last;
  logic                 issue_zero;
  logic                 feat_done;

  // Pipeline, stage 1 waits on H, stage 2 on W
  logic                 v1, l1, z1;
  logic                 v2, l2, z2;
  logic signed [DW-1:0] h_val2;
  logic signed [2*DW-1:0] prod;
  logic signed [WHW-1:0]  prod_ext;
  logic signed [WHW-1:0]  acc;
  logic signed [WHW-1:0]  acc_next;

  // Result write registers
  logic                          wr_en_q;
  logic [`GAT_FEAT_ADDR_W-1:0]   wr_addr_q;
  logic signed [WHW-1:0]         wr_data_q;

  assign all_loaded = h_data_bram_load_done && h_node_info_bram_load_done &&
                      wgt_bram_load_done;

  // Empty row still sends one item, with a zero product
  assign issue      = (state == S_STREAM);
  assign issue_zero = (row_len == '0);
  assign issue_last = issue_zero || (k == row_len - 1'b1);

  // Last product of the current feature lands this cycle
  assign feat_done  = v2 && l2;

  // ==========================================================================
  // Memory addressing
  // ==========================================================================

  assign node_info_rd_en = (state == S_FETCH) && !len_req;
  assign node_info_addrb = node;

  assign h_data_rd_en    = issue && !issue_zero;
  assign h_data_addrb    = row_base + HAW'(k);

  // 16 output features, so c * 16 + f is a concatenation
  assign wgt_rd_en       = v1 && !z1;
  assign wgt_addrb       = {h_data_dout.col_idx, feat};

  // ==========================================================================
  // FSM over nodes and features
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      len_req   <= 1'b0;
      node      <= '0;
      feat      <= '0;
      row_base  <= '0;
      row_len   <= '0;
      k         <= '0;
      gat_ready <= 1'b0;
    end else begin
      case (state)
        // Load-done levels only matter here
        S_IDLE: begin
          if (all_loaded) begin
            state <= S_FETCH;
          end
        end
        // Address out, then row length back
        S_FETCH: begin
          if (!len_req) begin
            len_req <= 1'b1;
          end else begin
            len_req <= 1'b0;
            row_len <= node_info_dout;
            k       <= '0;
            state   <= S_STREAM;
          end
        end
        // One nonzero address per cycle
        S_STREAM: begin
          if (issue_last) begin
            k     <= '0;
            state <= S_DRAIN;
          end else begin
            k <= k + 1'b1;
          end
        end
        S_DRAIN: begin
          if (feat_done) begin
            if (feat == FW'(LAST_FEAT)) begin
              feat     <= '0;
              row_base <= row_base + HAW'(row_len);
              if (node == NAW'(LAST_NODE)) begin
                state <= S_DONE;
              end else begin
                node  <= node + 1'b1;
                state <= S_FETCH;
              end
            end else begin
              feat  <= feat + 1'b1;
              state <= S_STREAM;
            end
          end
        end
        // Raised a cycle after the last write, held until reset
        S_DONE: begin
          gat_ready <= 1'b1;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ==========================================================================
  // Multiply and accumulate
  // ==========================================================================

  assign prod     = h_val2 * $signed(wgt_dout);
  // Empty row item adds nothing
  assign prod_ext = z2 ? '0 : {{(WHW-2*DW){prod[2*DW-1]}}, prod};
  assign acc_next = acc + prod_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1      <= 1'b0;
      l1      <= 1'b0;
      z1      <= 1'b0;
      v2      <= 1'b0;
      l2      <= 1'b0;
      z2      <= 1'b0;
      acc     <= '0;
      wr_en_q <= 1'b0;
    end else begin
      v1      <= issue;
      l1      <= issue && issue_last;
      z1      <= issue && issue_zero;
      v2      <= v1;
      l2      <= l1;
      z2      <= z1;
      wr_en_q <= feat_done;
      if (v2) begin
        // Clear for the next feature once the sum leaves
        acc <= l2 ? '0 : acc_next;
      end
    end
  end

  // H value waits one cycle for its weight
  always_ff @(posedge clk) begin
    h_val2 <= h_data_dout.value;
    if (feat_done) begin
      wr_addr_q <= {node, feat};
      wr_data_q <= acc_next;
    end
  end

  assign feat_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

// ==== logic/input_bram.sv ====
`timescale 1ns/1ns

module input_bram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 64
) (
  input  logic                               clk,
  input  logic [$clog2(DEPTH)+WIDTH+1:0]     wr,
  input  logic [$clog2(DEPTH)-1:0]           addrb,
  input  logic                               rd_en,
  output logic [WIDTH-1:0]                   doutb
);

  localparam int AW = $clog2(DEPTH);

  // Same field order as the host write structs
  typedef struct packed {
    logic             ena;
    logic             wea;
    logic [AW-1:0]    addra;
    logic [WIDTH-1:0] din;
  } wr_port_t;

  wr_port_t         wr_s;
  logic [WIDTH-1:0] mem [DEPTH];

  assign wr_s = wr;

  // Port A, host writes
  always_ff @(posedge clk) begin
    if (wr_s.ena && wr_s.wea) begin
      mem[wr_s.addra] <= wr_s.din;
    end
  end

  // Port B, registered read, doutb holds while rd_en low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      doutb <= mem[addrb];
    end
  end

endmodule

// ==== logic/gat_pkg.sv ====
package gat_pkg;

  `include "gat_consts.svh"

  // ==========================================================================
  // Sparse H word
  // ==========================================================================

  // One nonzero of H, value above column index
  typedef struct packed {
    logic signed [`GAT_DATA_WIDTH-1:0]    value;
    logic        [`GAT_COL_IDX_WIDTH-1:0] col_idx;
  } h_data_t;

  // ==========================================================================
  // Host write ports, one per input memory
  // ==========================================================================

  typedef struct packed {
    logic                          ena;
    logic                          wea;
    logic [`GAT_H_DATA_ADDR_W-1:0] addra;
    h_data_t                       din;
  } h_data_wr_t;

  // Row length only, node count and flag not kept
  typedef struct packed {
    logic                          ena;
    logic                          wea;
    logic [`GAT_NODE_ADDR_W-1:0]   addra;
    logic [`GAT_ROW_LEN_WIDTH-1:0] din;
  } node_info_wr_t;

  typedef struct packed {
    logic                          ena;
    logic                          wea;
    logic [`GAT_WEIGHT_ADDR_W-1:0] addra;
    logic [`GAT_DATA_WIDTH-1:0]    din;
  } wgt_wr_t;

  // ==========================================================================
  // Result memory traffic
  // ==========================================================================

  // Engine side, one finished sum per en pulse
  typedef struct packed {
    logic                                 en;
    logic        [`GAT_FEAT_ADDR_W-1:0]   addr;
    logic signed [`GAT_WH_DATA_WIDTH-1:0] data;
  } feat_wr_t;

  // Host side, rd_en held until rvalid
  typedef struct packed {
    logic                        rd_en;
    logic [`GAT_FEAT_ADDR_W-1:0] addr;
  } feat_rd_req_t;

endpackage

// ==== logic/gat_consts.svh ====
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// ==========================================================================
// Dataset sizes for the first layer feature transform
// ==========================================================================

// H values and weights, signed
`define GAT_DATA_WIDTH          8
`define GAT_TOTAL_NODES         8
`define GAT_NUM_FEATURE_IN      11
`define GAT_NUM_FEATURE_OUT     16

// Sparse H storage
`define GAT_COL_IDX_WIDTH       4
`define GAT_H_DATA_DEPTH        64
`define GAT_H_DATA_ADDR_W       6
`define GAT_ROW_LEN_WIDTH       4
`define GAT_NODE_ADDR_W         3

// Dense W, input features times output features
`define GAT_WEIGHT_DEPTH        176
`define GAT_WEIGHT_ADDR_W       8

// WH results, nodes times output features
`define GAT_WH_DATA_WIDTH       20
`define GAT_FEAT_DEPTH          128
`define GAT_FEAT_ADDR_W         7
`define GAT_NEW_FEATURE_WIDTH   32

`endif
